/* bench/board_ctrl_cases.txt */
// op_addr_data_expected; op 1 write, 2 read, 3 set inputs, 4 idle, 5 random scratch
// write/idle expected = {pwr_enable, relay_on, dout, amp_disable}, read expected = prdata
4_00_00000001_0000000F
2_00_00000000_45020000
2_03_00000000_0000FFFF
2_04_00000000_514C4131
2_07_00000000_00000001
1_00_00000F05_0000000A
1_00_00000302_00000009
1_00_00070000_00000109
1_00_000C0000_00000309
2_00_00000000_45070006
1_06_00000F0C_000003C9
1_06_00000501_00000399
2_06_00000000_00000009
5_01_00000000_00000000
5_02_00000000_00000000
5_03_00000000_00000000
1_03_0000FFFF_00000399
3_00_0007A3C6_00000000
2_0A_00000000_000196C3
2_00_00000000_450D0A06
3_01_ABCD5A17_00000000
2_05_00000000_00005A17
3_02_C0FFEE01_00000000
2_08_00000000_C0FFEE01
3_03_0BADF00D_00000000
2_09_00000000_0BADF00D
1_30_000F0F0F_00000399
2_10_00000000_00000000
2_0B_00000000_00000000
2_0F_00000000_00000000
1_04_00000000_00000399
2_04_00000000_514C4131
2_00_00000000_450D0A06
1_03_00000002_00000399
1_00_00000F0F_00000390
4_00_00000500_0000039F
2_00_00000000_458D0A00
1_01_00000000_0000039F
2_00_00000000_450D0A00
1_03_00000000_0000039F
1_00_00000F0F_00000390
4_00_00000500_00000390
2_00_00000000_450D0A0F

/* board_ctrl.f */
logic/board_regs_pkg.sv
logic/board_io_pkg.sv
logic/apb_reg_port.sv
logic/input_sync.sv
logic/wdog_timer.sv
logic/board_regs.sv
logic/board_ctrl.sv
bench/tb_clock_gen.sv
bench/board_ctrl_tb.sv

/* Bender.yml */
package:
  name: board_ctrl

sources:
  # rtl group, packages first
  - files:
      - logic/board_regs_pkg.sv
      - logic/board_io_pkg.sv
      - logic/apb_reg_port.sv
      - logic/input_sync.sv
      - logic/wdog_timer.sv
      - logic/board_regs.sv
      - logic/board_ctrl.sv
  # test group, top module board_ctrl_tb
  - target: test
    files:
      - bench/tb_clock_gen.sv
      - bench/board_ctrl_tb.sv

/* bench/board_ctrl_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module board_ctrl_tb;
    import board_io_pkg::*;

    localparam int max_cases = 64;

    logic        sysclk, reset;
    logic [7:0]  paddr;                 // apb host side
    logic        psel, penable, pwrite;
    logic [31:0] pwdata, prdata;
    logic        pready, pslverr;
    logic [3:0]  neg_limit_pin, pos_limit_pin, home_pin, fault_pin;
    logic        relay_pin, mv_good_pin, v_fault_pin;
    logic [3:0]  board_id;
    logic [15:0] temp_sense;
    logic [31:0] prom_status, prom_result;
    logic [3:0]  amp_disable, dout;     // board controls
    logic        relay_on, pwr_enable;

    logic [75:0] case_mem [max_cases];  // op, addr, data, expected
    int          n_cases;
    int          case_errs;             // failed checks in the running case
    int          n_pass, n_fail;
    logic [31:0] lfsr_q = 32'hb8f2;

    tb_clock_gen clk_i (.sysclk, .reset);

    board_ctrl dut_i (
        .sysclk, .reset,
        .paddr, .psel, .penable, .pwrite, .pwdata, .prdata, .pready, .pslverr,
        .neg_limit_pin, .pos_limit_pin, .home_pin, .fault_pin,
        .relay_pin, .mv_good_pin, .v_fault_pin,
        .board_id, .temp_sense, .prom_status, .prom_result,
        .amp_disable, .dout, .relay_on, .pwr_enable
    );

    // --------------------
    // helpers
    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_word(output logic [31:0] w);
        for (int b = 0; b < 32; b++) begin
            lfsr_q = lfsr_next(lfsr_q);         // one step per bit
            w = {w[30:0], lfsr_q[0]};
        end
    endtask

    // slave error rule: outside channel 0, unmapped, or write to read-only
    function automatic logic expect_err(input logic wr, input logic [7:0] addr);
        if (addr[7:4] != 4'd0 || addr[3:0] > 4'd10) return 1'b1;
        return wr && !(addr[3:0] <= 4'd3 || addr[3:0] == 4'd6);
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        assert (got === exp) else begin
            $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, exp, got);
            case_errs++;
        end
    endtask

    // setup, access, then idle; response sampled mid access
    task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] data,
                            output logic [31:0] rdata, output logic err);
        @(posedge sysclk);
        paddr   <= addr;
        pwrite  <= wr;
        pwdata  <= data;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge sysclk);
        penable <= 1'b1;
        @(negedge sysclk);
        rdata = prdata;
        err   = pslverr;
        check_value("pready", 32'd1, pready);
        @(posedge sysclk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    // port word: amp_disable 3:0, dout 7:4, relay_on 8, pwr_enable 9
    task automatic check_ports(input logic [31:0] exp);
        @(negedge sysclk);
        check_value("amp_disable", exp[3:0], amp_disable);
        check_value("dout", exp[7:4], dout);
        check_value("relay_on", exp[8], relay_on);
        check_value("pwr_enable", exp[9], pwr_enable);
    endtask

    task automatic set_inputs(input logic [7:0] sel, input logic [31:0] val);
        @(posedge sysclk);
        case (sel)
            8'h00: begin
                neg_limit_pin <= val[3:0];
                pos_limit_pin <= val[7:4];
                home_pin      <= val[11:8];
                fault_pin     <= val[15:12];
                {v_fault_pin, mv_good_pin, relay_pin} <= val[18:16];
            end
            8'h01: temp_sense  <= val[15:0];
            8'h02: prom_status <= val;
            8'h03: prom_result <= val;
            default: begin
                $display("case selects unknown input group %h", sel);
                case_errs++;
            end
        endcase
        repeat (4) @(posedge sysclk);       // settle through the synchronizer
    endtask

    // --------------------
    // case loop
    initial begin : run_cases
        logic [3:0]  op;
        logic [7:0]  addr;
        logic [31:0] data, exp_val, rdata, rnd;
        logic        err;

        paddr = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        pwdata = '0;
        {neg_limit_pin, pos_limit_pin, home_pin, fault_pin} = '0;
        {relay_pin, mv_good_pin, v_fault_pin} = '0;
        board_id = 4'h5;                    // fixed strap
        temp_sense = '0;
        prom_status = '0;
        prom_result = '0;
        n_pass = 0;
        n_fail = 0;

        for (int i = 0; i < max_cases; i++) case_mem[i] = '0;
        $readmemh("bench/board_ctrl_cases.txt", case_mem);
        n_cases = 0;
        while (n_cases < max_cases && case_mem[n_cases][75:72] != 4'd0) n_cases++;

        wait (reset === 1'b1);
        for (int i = 0; i < n_cases; i++) begin
            {op, addr, data, exp_val} = case_mem[i];
            case_errs = 0;
            case (op)
                4'd1: begin                 // write, then port state
                    apb_xfer(1'b1, addr, data, rdata, err);
                    check_value("pslverr", expect_err(1'b1, addr), err);
                    check_ports(exp_val);
                end
                4'd2: begin                 // read
                    apb_xfer(1'b0, addr, 32'd0, rdata, err);
                    check_value("pslverr", expect_err(1'b0, addr), err);
                    check_value("prdata", exp_val, rdata);
                end
                4'd3: set_inputs(addr, data);
                4'd4: begin                 // idle, host silent
                    repeat (data) @(posedge sysclk);
                    check_ports(exp_val);
                end
                4'd5: begin                 // random scratch round trip
                    rand_word(rnd);
                    apb_xfer(1'b1, addr, rnd, rdata, err);
                    check_value("pslverr", 32'd0, err);
                    apb_xfer(1'b0, addr, 32'd0, rdata, err);
                    check_value("prdata", {16'd0, rnd[15:0]}, rdata);
                end
                default: begin
                    $display("case %0d has unknown operation %0d", i, op);
                    case_errs++;
                end
            endcase
            if (case_errs == 0) n_pass++;
            else n_fail++;
            $display("case %0d op %0d addr %h: %s", i, op, addr, case_errs ? "FAIL" : "ok");
        end

        if (n_cases == 0) begin
            $display("no cases were loaded from the case file");
            n_fail++;
        end
        $display("%0d cases passed, %0d cases failed", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // run limit, scaled by case count plus three full watchdog waits
    initial begin : run_limit
        wait (n_cases > 0);
        repeat (n_cases * 1200 + 3 * (1 << wdog_prescale_w) * 16) @(posedge sysclk);
        $display("run did not finish in time, stopped by the bench");
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

/* bench/tb_clock_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
    output logic sysclk,
    output logic reset      // sync, active low
);

    // 10 ns period
    initial begin
        sysclk = 1'b0;
        forever #5 sysclk = ~sysclk;
    end

    // held low for 5 rising edges
    initial begin
        reset = 1'b0;
        repeat (5) @(posedge sysclk);
        reset <= 1'b1;
    end

endmodule

`default_nettype wire

/* logic/board_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module board_ctrl (
    input  logic                              sysclk,
    input  logic                              reset,
    // apb slave
    input  logic [7:0]                        paddr,
    input  logic                              psel,
    input  logic                              penable,
    input  logic                              pwrite,
    input  logic [31:0]                       pwdata,
    output logic [31:0]                       prdata,
    output logic                              pready,
    output logic                              pslverr,
    // board pins
    input  logic [board_io_pkg::num_axes-1:0] neg_limit_pin,
    input  logic [board_io_pkg::num_axes-1:0] pos_limit_pin,
    input  logic [board_io_pkg::num_axes-1:0] home_pin,
    input  logic [board_io_pkg::num_axes-1:0] fault_pin,
    input  logic                              relay_pin,
    input  logic                              mv_good_pin,
    input  logic                              v_fault_pin,
    input  logic [3:0]                        board_id,
    input  logic [15:0]                       temp_sense,
    input  logic [31:0]                       prom_status,
    input  logic [31:0]                       prom_result,
    // board controls
    output logic [board_io_pkg::num_axes-1:0] amp_disable,
    output logic [board_io_pkg::num_axes-1:0] dout,
    output logic                              relay_on,
    output logic                              pwr_enable
);
    import board_regs_pkg::*;
    import board_io_pkg::*;

    logic [reg_index_w-1:0] reg_index;
    logic                   rd_en;
    logic                   wr_en;          // also kicks the watchdog
    logic                   wdog_timeout;
    logic [15:0]            wdog_period;
    logic [num_axes-1:0]    neg_limit, pos_limit, home, fault;
    logic                   relay, mv_good, v_fault;

    apb_reg_port port_i (
        .sysclk, .reset,
        .paddr, .psel, .penable, .pwrite,
        .pready, .pslverr,
        .reg_index, .rd_en, .wr_en
    );

    input_sync sync_i (
        .sysclk, .reset,
        .neg_limit_pin, .pos_limit_pin, .home_pin, .fault_pin,
        .relay_pin, .mv_good_pin, .v_fault_pin,
        .neg_limit, .pos_limit, .home, .fault,
        .relay, .mv_good, .v_fault
    );

    wdog_timer wdog_i (
        .sysclk, .reset,
        .wr_en,
        .period (wdog_period),
        .wdog_timeout
    );

    board_regs regs_i (
        .sysclk, .reset,
        .reg_index, .reg_wdata (pwdata), .wr_en, .rd_en,
        .reg_rdata (prdata),
        .wdog_timeout, .wdog_period,
        .neg_limit, .pos_limit, .home, .fault,
        .relay, .mv_good, .v_fault,
        .board_id, .temp_sense, .prom_status, .prom_result,
        .amp_disable, .dout, .relay_on, .pwr_enable
    );

endmodule

`default_nettype wire

/* logic/board_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module board_regs (
    input  logic                                   sysclk,
    input  logic                                   reset,
    // from apb port
    input  logic [board_regs_pkg::reg_index_w-1:0] reg_index,
    input  logic [31:0]                            reg_wdata,
    input  logic                                   wr_en,
    input  logic                                   rd_en,
    output logic [31:0]                            reg_rdata,
    // watchdog
    input  logic                                   wdog_timeout,
    output logic [15:0]                            wdog_period,
    // synchronized board pins
    input  logic [board_io_pkg::num_axes-1:0]      neg_limit,
    input  logic [board_io_pkg::num_axes-1:0]      pos_limit,
    input  logic [board_io_pkg::num_axes-1:0]      home,
    input  logic [board_io_pkg::num_axes-1:0]      fault,
    input  logic                                   relay,
    input  logic                                   mv_good,
    input  logic                                   v_fault,
    // straps and sampled buses
    input  logic [3:0]                             board_id,
    input  logic [15:0]                            temp_sense,
    input  logic [31:0]                            prom_status,
    input  logic [31:0]                            prom_result,
    // board controls
    output logic [board_io_pkg::num_axes-1:0]      amp_disable,
    output logic [board_io_pkg::num_axes-1:0]      dout,
    output logic                                   relay_on,
    output logic                                   pwr_enable
);
    import board_regs_pkg::*;
    import board_io_pkg::*;

    status_word_u wr_word;      // host write, decoded as value/mask
    status_word_u rd_word;      // live status for reads
    logic [15:0]  phy_ctrl;     // scratch only, no phy behind it
    logic [15:0]  phy_data;
    logic [31:0]  rd_mux;

    // keep bits outside mask, take val inside
    function automatic logic [num_axes-1:0] masked_update(
        input logic [num_axes-1:0] cur,
        input logic [num_axes-1:0] val,
        input logic [num_axes-1:0] mask
    );
        return (cur & ~mask) | (val & mask);
    endfunction

    assign wr_word = reg_wdata;

    // --------------------
    // control registers
    always_ff @(posedge sysclk) begin
        if (!reset) begin
            amp_disable <= '1;              // power up with amps off
            relay_on    <= 1'b0;
            pwr_enable  <= 1'b0;
            dout        <= '0;
            wdog_period <= 16'hFFFF;
        end else begin
            // lost host, kill all amps; a write below can re-enable
            if (wdog_timeout) amp_disable <= '1;
            if (wr_en) begin
                case (reg_index)
                    reg_status: begin
                        // disable is the inverse of the enable value
                        amp_disable <= masked_update(amp_disable,
                                                     ~wr_word.wr.amp_val,
                                                     wr_word.wr.amp_mask);
                        if (wr_word.wr.relay_mask) relay_on <= wr_word.wr.relay_val;
                        if (wr_word.wr.pwr_mask) pwr_enable <= wr_word.wr.pwr_val;
                    end
                    reg_timeout: wdog_period <= reg_wdata[15:0];
                    reg_digiout: begin
                        // same value/mask layout as the amp field
                        dout <= masked_update(dout, wr_word.wr.amp_val, wr_word.wr.amp_mask);
                    end
                    default: ;              // read-only, rejected by port
                endcase
            end
        end
    end

    // phy scratch words
    always_ff @(posedge sysclk) begin
        if (wr_en && reg_index == reg_phyctrl) phy_ctrl <= reg_wdata[15:0];
        if (wr_en && reg_index == reg_phydata) phy_data <= reg_wdata[15:0];
    end

    // --------------------
    // read side
    always_comb begin
        rd_word                = '0;
        rd_word.rd.num_chan    = 4'(num_axes);
        rd_word.rd.board_id    = board_id;
        rd_word.rd.wdog_timeout = wdog_timeout;
        rd_word.rd.mv_good     = mv_good;
        rd_word.rd.pwr_enable  = pwr_enable;
        rd_word.rd.relay_fb_n  = ~relay;        // pin is active low
        rd_word.rd.relay_on    = relay_on;
        rd_word.rd.fault       = fault;
        rd_word.rd.amp_enabled = ~amp_disable;
    end

    always_comb begin
        case (reg_index)
            reg_status:     rd_mux = rd_word;
            reg_phyctrl:    rd_mux = {16'd0, phy_ctrl};
            reg_phydata:    rd_mux = {16'd0, phy_data};
            reg_timeout:    rd_mux = {16'd0, wdog_period};
            reg_version:    rd_mux = board_version;
            reg_tempsns:    rd_mux = {16'd0, temp_sense};
            reg_digiout:    rd_mux = {28'd0, dout};
            reg_fw_version: rd_mux = fw_version;
            reg_promstat:   rd_mux = prom_status;
            reg_promres:    rd_mux = prom_result;
            // home low, then pos, neg, dout echo, v_fault at 16
            reg_digin:      rd_mux = {15'd0, v_fault, dout, neg_limit, pos_limit, home};
            default:        rd_mux = 32'd0;
        endcase
    end

    // loaded in setup, zero otherwise so errored reads return 0
    always_ff @(posedge sysclk) begin
        if (!reset) begin
            reg_rdata <= 32'd0;
        end else begin
            reg_rdata <= rd_en ? rd_mux : 32'd0;
        end
    end

endmodule

`default_nettype wire

/* logic/wdog_timer.sv */
`timescale 1ns/100ps
`default_nettype none

module wdog_timer #(
    parameter int prescale_w = board_io_pkg::wdog_prescale_w  // tick = 2**prescale_w clocks
) (
    input  logic        sysclk,
    input  logic        reset,
    input  logic        wr_en,          // any accepted host write
    input  logic [15:0] period,         // in ticks, 0 = off
    output logic        wdog_timeout
);

    logic [prescale_w-1:0] prescale_q;  // free running divider
    logic                  tick;
    logic [15:0]           count_q;     // ticks since last write

    // --------------------
    // prescaler
    always_ff @(posedge sysclk) begin
        if (!reset) begin
            prescale_q <= '0;
        end else begin
            prescale_q <= prescale_q + 1'b1;
        end
    end

    assign tick = &prescale_q;          // once per wrap

    // --------------------
    // tick counter and sticky flag
    always_ff @(posedge sysclk) begin
        if (!reset) begin
            count_q      <= '0;
            wdog_timeout <= 1'b0;
        end else if (wr_en) begin
            // host is alive, start over
            count_q      <= '0;
            wdog_timeout <= 1'b0;
        end else if (tick && period != 16'd0) begin
            if (count_q < period) begin
                count_q <= count_q + 1'b1;
            end else begin
                wdog_timeout <= 1'b1;   // holds until the next write
            end
        end
    end

endmodule

`default_nettype wire

/* logic/input_sync.sv */
`timescale 1ns/100ps
`default_nettype none

module input_sync (
    input  logic                              sysclk,
    input  logic                              reset,
    // raw board pins, asynchronous
    input  logic [board_io_pkg::num_axes-1:0] neg_limit_pin,
    input  logic [board_io_pkg::num_axes-1:0] pos_limit_pin,
    input  logic [board_io_pkg::num_axes-1:0] home_pin,
    input  logic [board_io_pkg::num_axes-1:0] fault_pin,
    input  logic                              relay_pin,
    input  logic                              mv_good_pin,
    input  logic                              v_fault_pin,
    // sysclk domain copies
    output logic [board_io_pkg::num_axes-1:0] neg_limit,
    output logic [board_io_pkg::num_axes-1:0] pos_limit,
    output logic [board_io_pkg::num_axes-1:0] home,
    output logic [board_io_pkg::num_axes-1:0] fault,
    output logic                              relay,
    output logic                              mv_good,
    output logic                              v_fault
);
    import board_io_pkg::*;

    localparam int pin_w = 4 * num_axes + 3;   // four per-axis groups plus three singles

    logic [pin_w-1:0] pin_vec;
    logic [pin_w-1:0] sync_q [sync_stages];    // [0] is the metastable stage

    assign pin_vec = {v_fault_pin, mv_good_pin, relay_pin,
                      fault_pin, home_pin, pos_limit_pin, neg_limit_pin};

    always_ff @(posedge sysclk) begin
        if (!reset) begin
            for (int i = 0; i < sync_stages; i++) sync_q[i] <= '0;
        end else begin
            sync_q[0] <= pin_vec;
            for (int i = 1; i < sync_stages; i++) sync_q[i] <= sync_q[i-1];
        end
    end

    // unpack the last stage in the same order
    assign {v_fault, mv_good, relay, fault, home, pos_limit, neg_limit} =
        sync_q[sync_stages-1];

endmodule

`default_nettype wire

/* logic/apb_reg_port.sv */
`timescale 1ns/100ps
`default_nettype none

module apb_reg_port (
    input  logic                                 sysclk,
    input  logic                                 reset,      // sync, active low
    // apb slave side
    input  logic [7:0]                           paddr,
    input  logic                                 psel,
    input  logic                                 penable,
    input  logic                                 pwrite,
    output logic                                 pready,
    output logic                                 pslverr,
    // register file side
    output logic [board_regs_pkg::reg_index_w-1:0] reg_index,
    output logic                                 rd_en,
    output logic                                 wr_en
);
    import board_regs_pkg::*;

    logic setup_phase;      // psel, no penable
    logic access_phase;     // psel and penable
    logic chan_err;         // outside channel 0
    logic index_err;        // unmapped index
    logic ro_err;           // write to a read-only index
    logic addr_err;
    logic err_q;            // error held for the access cycle

    assign setup_phase  = psel & ~penable;
    assign access_phase = psel & penable;

    // host keeps paddr stable from setup through access
    assign reg_index = paddr[reg_index_w-1:0];

    // --------------------
    // address check
    assign chan_err  = |paddr[7:4];                        // spi channels not here
    assign index_err = reg_index > reg_last;
    assign ro_err    = pwrite & ~reg_writable[reg_index];
    assign addr_err  = chan_err | index_err | ro_err;

    always_ff @(posedge sysclk) begin
        if (!reset) begin
            err_q <= 1'b0;
        end else begin
            err_q <= setup_phase & addr_err;               // drops again after access
        end
    end

    // --------------------
    // strobes
    // read strobe in setup so the file can register data for access
    assign rd_en = setup_phase & ~pwrite & ~addr_err;
    // write strobe in access, one pulse per transfer
    assign wr_en = access_phase & pwrite & ~err_q;

    // zero wait states
    assign pready  = 1'b1;
    assign pslverr = err_q;

endmodule

`default_nettype wire

/* logic/board_io_pkg.sv */
`default_nettype none

package board_io_pkg;

    // --------------------
    // board geometry
    localparam int num_axes = 4;        // amp channels on the card

    // --------------------
    // watchdog
    // prescaler bits, one tick every 2**8 = 256 sysclk cycles
    localparam int wdog_prescale_w = 8;

    // --------------------
    // pin synchronizer
    localparam int sync_stages = 2;     // flops per async pin

endpackage

`default_nettype wire

/* logic/board_regs_pkg.sv */
`default_nettype none

package board_regs_pkg;

    // --------------------
    // channel 0 register map
    localparam int unsigned reg_index_w = 4;                // in-channel index, paddr[3:0]

    localparam logic [reg_index_w-1:0] reg_status     = 4'd0;   // enables, masks, faults
    localparam logic [reg_index_w-1:0] reg_phyctrl    = 4'd1;   // phy request scratch
    localparam logic [reg_index_w-1:0] reg_phydata    = 4'd2;   // phy data scratch
    localparam logic [reg_index_w-1:0] reg_timeout    = 4'd3;   // watchdog period
    localparam logic [reg_index_w-1:0] reg_version    = 4'd4;   // board version, read only
    localparam logic [reg_index_w-1:0] reg_tempsns    = 4'd5;   // temperature sensors
    localparam logic [reg_index_w-1:0] reg_digiout    = 4'd6;   // digital outputs
    localparam logic [reg_index_w-1:0] reg_fw_version = 4'd7;   // firmware version
    localparam logic [reg_index_w-1:0] reg_promstat   = 4'd8;   // prom status
    localparam logic [reg_index_w-1:0] reg_promres    = 4'd9;   // prom result
    localparam logic [reg_index_w-1:0] reg_digin      = 4'd10;  // home, limits, dout echo
    localparam logic [reg_index_w-1:0] reg_last       = 4'd10;  // anything above is unmapped

    localparam logic [31:0] board_version = 32'h514C4131;   // ascii "QLA1"
    localparam logic [31:0] fw_version    = 32'd1;

    // one bit per index, 0-3 and 6 take writes
    localparam logic [15:0] reg_writable = 16'h004F;

    // --------------------
    // status word, two views of the same address

    // host write: value bits plus a mask selecting which ones apply
    typedef struct packed {
        logic [11:0] rsvd_hi;
        logic        pwr_mask;      // bit 19
        logic        pwr_val;       // bit 18
        logic        relay_mask;    // bit 17
        logic        relay_val;     // bit 16
        logic [3:0]  rsvd_mid;
        logic [3:0]  amp_mask;      // bits 11:8
        logic [3:0]  rsvd_lo;
        logic [3:0]  amp_val;       // bits 3:0, 1 = enable
    } status_wr_t;

    // host read: live board state
    typedef struct packed {
        logic [3:0]  num_chan;      // always 4 on this card
        logic [3:0]  board_id;      // rotary switch strap
        logic        wdog_timeout;  // bit 23
        logic [2:0]  rsvd_b2;
        logic        mv_good;       // motor supply ok
        logic        pwr_enable;
        logic        relay_fb_n;    // relay feedback, inverted
        logic        relay_on;
        logic [3:0]  rsvd_b1;
        logic [3:0]  fault;         // amp fault pins
        logic [3:0]  rsvd_b0;
        logic [3:0]  amp_enabled;   // inverse of amp_disable
    } status_rd_t;

    typedef union packed {
        status_wr_t wr;
        status_rd_t rd;
    } status_word_u;

endpackage

`default_nettype wire
